// ==== logic/exec_pkg.sv ====
/*
 * Shared definitions for the execute and writeback back end.
 * Holds the data widths, the opcode encoding, the status codes that
 * replace a result on an exception, and the packed structs carried
 * between issue, the two execution paths and the writeback merger.
 */
package exec_pkg;

    // ------------------------------------------------------------------
    // Widths and fixed register indices
    // ------------------------------------------------------------------
    localparam int XLEN  = 32;                  // Datapath width
    localparam int REG_W = 5;                   // Register index width

    localparam logic [REG_W-1:0] RSTATUS_REG = 5'd30;  // $rstatus

    // Decoded operation codes
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_SLL = 4'd4,
        OP_SRA = 4'd5,
        OP_MUL = 4'd6,
        OP_DIV = 4'd7
    } op_e;

    // Status codes written to $rstatus
    localparam logic [XLEN-1:0] EXC_ADD = 32'd1;
    localparam logic [XLEN-1:0] EXC_SUB = 32'd3;
    localparam logic [XLEN-1:0] EXC_MUL = 32'd4;
    localparam logic [XLEN-1:0] EXC_DIV = 32'd5;

    // ------------------------------------------------------------------
    // Payloads
    // ------------------------------------------------------------------
    typedef struct packed {
        op_e             op;                    // What to do
        logic [REG_W-1:0] dest;                 // Destination register
        logic [XLEN-1:0] opa;                   // First operand
        logic [XLEN-1:0] opb;                   // Second operand or shamt in [4:0]
    } exec_op_t;

    typedef struct packed {
        logic [REG_W-1:0] dest;
        logic [XLEN-1:0] value;                 // Result or status code
        logic            excpt;                 // Value is a status code
    } exec_res_t;

    typedef struct packed {
        logic [REG_W-1:0] dest;
        logic [XLEN-1:0] value;
    } wb_t;

endpackage

// ==== logic/pipe_reg.sv ====
/*
 * One-entry valid/ready register stage.
 * The payload type is a parameter, so the same stage holds ALU results
 * and final writebacks. A new item is taken when the stage is empty or
 * is being drained in the same cycle, so it runs at full rate.
 */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full_q;                           // Entry occupied
    payload_t data_q;

    assign in_ready  = ~full_q | out_ready;     // Empty, or emptying now
    assign out_valid = full_q;
    assign out_data  = data_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_ready) begin
            full_q <= in_valid;                 // Refill or go empty
        end
    end

    // Payload register
    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    // Held item must not change under back-pressure
    a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== logic/issue_ctrl.sv ====
/*
 * Issue control.
 * Steers each decoded operation to the ALU path or the multiply/divide
 * unit. An ALU op waits while mul/div is busy and a mul/div op waits
 * until the ALU path has drained, so results leave in program order.
 */
`timescale 1ns/1ps

module issue_ctrl (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               op_valid,
    output logic               op_ready,
    input  exec_pkg::exec_op_t op,
    output logic               alu_valid,
    input  logic               alu_ready,
    input  logic               alu_empty,
    output exec_pkg::exec_op_t alu_op,
    output logic               md_valid,
    input  logic               md_ready,
    output exec_pkg::exec_op_t md_op
);

    logic       is_md;                          // Op needs the mul/div unit
    logic       md_acc;                         // Mul/div handed over
    logic       md_rise;                        // Unit back to idle
    logic       md_ready_q;
    logic [1:0] md_cnt_q;                       // Issued, not yet retired

    // ------------------------------------------------------------------
    // Steering and ordering
    // ------------------------------------------------------------------
    assign is_md = (op.op == exec_pkg::OP_MUL) || (op.op == exec_pkg::OP_DIV);

    assign alu_valid = op_valid & ~is_md & md_ready;    // Hold behind mul/div
    assign md_valid  = op_valid & is_md & alu_empty;    // Hold until ALU drained

    // Ready comes back from whichever path the op is going to
    assign op_ready = md_ready & (is_md ? alu_empty : alu_ready);

    assign alu_op = op;
    assign md_op  = op;

    // ------------------------------------------------------------------
    // Outstanding mul/div tracking
    // ------------------------------------------------------------------
    assign md_acc  = md_valid & md_ready;
    assign md_rise = md_ready & ~md_ready_q;    // Result was retired

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            md_ready_q <= 1'b1;                 // Unit idles out of reset
            md_cnt_q   <= 2'd0;
        end else begin
            md_ready_q <= md_ready;
            md_cnt_q   <= md_cnt_q + {1'b0, md_acc} - {1'b0, md_rise};
        end
    end

    // A new mul/div only once the previous one has retired
    a_one_md: assert property (@(posedge clock) disable iff (!rst_n)
        md_acc |-> (md_cnt_q == 2'd0) || (md_cnt_q == 2'd1 && md_rise));

endmodule

// ==== logic/alu_pipe.sv ====
/*
 * Single-cycle ALU path.
 * Computes add, sub, and, or, sll and sra, flags signed overflow on
 * add and sub, and registers the result. On overflow the value is the
 * matching status code and excpt is set for the writeback merger.
 */
`timescale 1ns/1ps

module alu_pipe (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                alu_valid,
    output logic                alu_ready,
    input  exec_pkg::exec_op_t  alu_op,
    output logic                alu_empty,
    output logic                res_valid,
    input  logic                res_ready,
    output exec_pkg::exec_res_t res
);

    logic [exec_pkg::XLEN-1:0] sum, diff;
    logic                      add_ovf, sub_ovf;
    exec_pkg::exec_res_t       alu_res;         // Into the register stage

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    assign sum  = alu_op.opa + alu_op.opb;
    assign diff = alu_op.opa - alu_op.opb;

    // Same signs in, different sign out
    assign add_ovf = (alu_op.opa[31] == alu_op.opb[31]) && (sum[31] != alu_op.opa[31]);
    assign sub_ovf = (alu_op.opa[31] != alu_op.opb[31]) && (diff[31] != alu_op.opa[31]);

    always_comb begin
        alu_res.dest  = alu_op.dest;
        alu_res.excpt = 1'b0;
        case (alu_op.op)
            exec_pkg::OP_ADD: begin
                alu_res.excpt = add_ovf;
                alu_res.value = add_ovf ? exec_pkg::EXC_ADD : sum;
            end
            exec_pkg::OP_SUB: begin
                alu_res.excpt = sub_ovf;
                alu_res.value = sub_ovf ? exec_pkg::EXC_SUB : diff;
            end
            exec_pkg::OP_AND: alu_res.value = alu_op.opa & alu_op.opb;
            exec_pkg::OP_OR:  alu_res.value = alu_op.opa | alu_op.opb;
            exec_pkg::OP_SLL: alu_res.value = alu_op.opa << alu_op.opb[4:0];
            exec_pkg::OP_SRA: alu_res.value = $signed(alu_op.opa) >>> alu_op.opb[4:0];
            default:          alu_res.value = '0;   // Mul/div never steered here
        endcase
    end

    // ------------------------------------------------------------------
    // Result register
    // ------------------------------------------------------------------
    pipe_reg #(
        .payload_t (exec_pkg::exec_res_t)
    ) res_reg_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (alu_valid),
        .in_ready  (alu_ready),
        .in_data   (alu_res),
        .out_valid (res_valid),
        .out_ready (res_ready),
        .out_data  (res)
    );

    assign alu_empty = ~res_valid;              // Nothing left in flight here

endmodule

// ==== logic/multdiv_unit.sv ====
/*
 * Iterative multiply/divide unit.
 * Takes one operation when idle, runs XLEN shift steps on operand
 * magnitudes, then fixes the sign and checks for mul overflow or a zero
 * divisor. The result is held until the merger takes it, and only then
 * does the unit report ready again. Latency is XLEN+1 cycles.
 */
`timescale 1ns/1ps

module multdiv_unit (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                md_valid,
    output logic                md_ready,
    input  exec_pkg::exec_op_t  md_op,
    output logic                res_valid,
    input  logic                res_ready,
    output exec_pkg::exec_res_t res
);

    localparam int XLEN  = exec_pkg::XLEN;
    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_FIN, ST_DONE} md_state_e;

    md_state_e                   state_q;
    logic [CNT_W-1:0]            cnt_q;         // Step number
    logic                        div_q, neg_q;  // Operation, result sign
    logic [exec_pkg::REG_W-1:0]  dest_q;
    logic [XLEN-1:0]             hi_q, lo_q;    // Product or remainder/quotient
    logic [XLEN-1:0]             mag_b_q;
    exec_pkg::exec_res_t         res_q;
    logic [XLEN-1:0]             mag_a, mag_b;
    logic [XLEN:0]               mul_sum, div_shift;
    logic [XLEN+1:0]             div_diff;
    logic                        borrow, mul_ovf, div_zero;
    logic [2*XLEN-1:0]           prod_s;
    logic [XLEN-1:0]             quot_s;

    assign md_ready  = (state_q == ST_IDLE);
    assign res_valid = (state_q == ST_DONE);
    assign res       = res_q;

    // ------------------------------------------------------------------
    // Step logic
    // ------------------------------------------------------------------
    assign mag_a = md_op.opa[XLEN-1] ? -md_op.opa : md_op.opa;
    assign mag_b = md_op.opb[XLEN-1] ? -md_op.opb : md_op.opb;

    assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, mag_b_q} : '0);  // Add if bit set
    assign div_shift = {hi_q, lo_q[XLEN-1]};            // Bring down next bit
    assign div_diff  = {1'b0, div_shift} - {2'b00, mag_b_q};
    assign borrow    = div_diff[XLEN+1];                // Divisor didn't fit

    // Sign fixup and checks
    assign prod_s   = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
    assign mul_ovf  = prod_s[2*XLEN-1:XLEN] != {XLEN{prod_s[XLEN-1]}};
    assign quot_s   = neg_q ? -lo_q : lo_q;             // Truncates toward zero
    assign div_zero = (mag_b_q == '0);

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (md_valid) begin
                    state_q <= ST_BUSY;
                    cnt_q   <= '0;
                end
                ST_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(XLEN - 1)) state_q <= ST_FIN;
                end
                ST_FIN:  state_q <= ST_DONE;
                ST_DONE: if (res_ready) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clock) begin
        if (state_q == ST_IDLE && md_valid) begin
            hi_q    <= '0;
            lo_q    <= mag_a;
            mag_b_q <= mag_b;
            div_q   <= (md_op.op == exec_pkg::OP_DIV);
            neg_q   <= md_op.opa[XLEN-1] ^ md_op.opb[XLEN-1];
            dest_q  <= md_op.dest;
        end else if (state_q == ST_BUSY) begin
            if (div_q) begin                    // Restoring divide step
                hi_q <= borrow ? div_shift[XLEN-1:0] : div_diff[XLEN-1:0];
                lo_q <= {lo_q[XLEN-2:0], ~borrow};
            end else begin
                {hi_q, lo_q} <= {mul_sum, lo_q[XLEN-1:1]};  // Shift-add step
            end
        end else if (state_q == ST_FIN) begin
            res_q.dest <= dest_q;
            if (div_q) begin
                res_q.excpt <= div_zero;
                res_q.value <= div_zero ? exec_pkg::EXC_DIV : quot_s;
            end else begin
                res_q.excpt <= mul_ovf;
                res_q.value <= mul_ovf ? exec_pkg::EXC_MUL : prod_s[XLEN-1:0];
            end
        end
    end

    // Busy from acceptance until the merger has the result
    a_busy_after_acc: assert property (@(posedge clock) disable iff (!rst_n)
        md_valid && md_ready |=> !md_ready);
    a_idle_after_take: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(md_ready) |-> $past(res_valid && res_ready));

endmodule

// ==== logic/result_merge.sv ====
/*
 * Writeback merger.
 * Takes whichever execution path has a result, redirects exceptions to
 * the status register, and registers the final write. Issue ordering
 * keeps the two inputs from ever being valid together.
 */
`timescale 1ns/1ps

module result_merge (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                alu_res_valid,
    output logic                alu_res_ready,
    input  exec_pkg::exec_res_t alu_res,
    input  logic                md_res_valid,
    output logic                md_res_ready,
    input  exec_pkg::exec_res_t md_res,
    output logic                wb_valid,
    input  logic                wb_ready,
    output exec_pkg::wb_t       wb
);

    exec_pkg::exec_res_t sel_res;               // Chosen stream
    exec_pkg::wb_t       wb_next;
    logic                in_valid, in_ready;

    // ------------------------------------------------------------------
    // Select and rewrite
    // ------------------------------------------------------------------
    assign sel_res  = md_res_valid ? md_res : alu_res;
    assign in_valid = alu_res_valid | md_res_valid;

    // Status code goes to $rstatus instead of the real destination
    assign wb_next.dest  = sel_res.excpt ? exec_pkg::RSTATUS_REG : sel_res.dest;
    assign wb_next.value = sel_res.value;

    // Only one side is ever valid, so both share the stage ready
    assign alu_res_ready = in_ready;
    assign md_res_ready  = in_ready;

    // ------------------------------------------------------------------
    // Writeback register
    // ------------------------------------------------------------------
    pipe_reg #(
        .payload_t (exec_pkg::wb_t)
    ) wb_reg_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (wb_next),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb)
    );

    a_one_source: assert property (@(posedge clock) disable iff (!rst_n)
        !(alu_res_valid && md_res_valid));

endmodule

// ==== logic/exec_core.sv ====
/*
 * Execute and writeback back end, top level.
 * Decoded ops enter through issue, run in the ALU path or the
 * multiply/divide unit, and leave as in-order register writes.
 */
`timescale 1ns/1ps

module exec_core (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               op_valid,
    output logic               op_ready,
    input  exec_pkg::exec_op_t op,
    output logic               wb_valid,
    input  logic               wb_ready,
    output exec_pkg::wb_t      wb
);

    // ------------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------------
    logic                alu_valid, alu_ready, alu_empty;    // Issue to ALU
    exec_pkg::exec_op_t  alu_op;
    logic                md_valid, md_ready;                 // Issue to mul/div
    exec_pkg::exec_op_t  md_op;
    logic                alu_res_valid, alu_res_ready;       // Paths to merger
    exec_pkg::exec_res_t alu_res;
    logic                md_res_valid, md_res_ready;
    exec_pkg::exec_res_t md_res;

    issue_ctrl issue_i (
        .clock, .rst_n, .op_valid, .op_ready, .op,
        .alu_valid, .alu_ready, .alu_empty, .alu_op,
        .md_valid, .md_ready, .md_op
    );

    alu_pipe alu_i (
        .clock, .rst_n, .alu_valid, .alu_ready, .alu_op, .alu_empty,
        .res_valid (alu_res_valid),
        .res_ready (alu_res_ready),
        .res       (alu_res)
    );

    multdiv_unit md_i (
        .clock, .rst_n, .md_valid, .md_ready, .md_op,
        .res_valid (md_res_valid),
        .res_ready (md_res_ready),
        .res       (md_res)
    );

    result_merge merge_i (
        .clock, .rst_n,
        .alu_res_valid, .alu_res_ready, .alu_res,
        .md_res_valid, .md_res_ready, .md_res,
        .wb_valid, .wb_ready, .wb
    );

endmodule

// ==== testbench/tb_exec_core.sv ====
/*
 * Testbench for the execute and writeback back end.
 * Sends a few directed corner ops, then xorshift-random decoded ops,
 * into exec_core while wb_ready drops at random. Expected writebacks go
 * into an in-order queue and concurrent assertions compare every write.
 */
`timescale 1ns/1ps

module tb_exec_core;

    localparam int          N_OPS      = 300;
    localparam int          MAX_CYCLES = 40 * N_OPS + 200;     // Timeout limit
    localparam logic [31:0] SEED       = 32'h1247;

    logic               clock;
    logic               rst_n;
    logic               op_valid;
    logic               op_ready;
    exec_pkg::exec_op_t op;
    logic               wb_valid;
    logic               wb_ready;
    exec_pkg::wb_t      wb;

    exec_pkg::wb_t      exp_mem [0:511];    // Expected writebacks in issue order
    logic [8:0]         wr_ptr, rd_ptr;
    exec_pkg::wb_t      exp_head;
    exec_pkg::wb_t      held_wb;            // wb one cycle back
    logic [31:0]        op_rng, gap_rng;    // Separate op and wb_ready streams
    int                 cycle_cnt;

    exec_core dut_i (
        .clock, .rst_n, .op_valid, .op_ready, .op,
        .wb_valid, .wb_ready, .wb
    );

    assign exp_head = exp_mem[rd_ptr];

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Biased toward zero, small and extreme values to hit the corners
    function automatic logic [31:0] pick_operand(input logic [31:0] r);
        logic [31:0] v;
        case (r[31:29])
            3'd0:    v = 32'd0;
            3'd1:    v = {{28{r[7]}}, r[7:4]};             // -8 to 7
            3'd2:    v = r[8] ? 32'h8000_0000 : 32'h7fff_ffff;
            3'd3:    v = {{16{r[15]}}, r[15:0]};
            default: v = r;
        endcase
        return v;
    endfunction

    function automatic exec_pkg::exec_op_t make_op(input exec_pkg::op_e opc,
                                                   input logic [4:0] d,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
        exec_pkg::exec_op_t o;
        o.op   = opc;
        o.dest = d;
        o.opa  = a;
        o.opb  = b;
        return o;
    endfunction

    // Reference result in 64-bit signed arithmetic
    function automatic exec_pkg::wb_t expected_wb(input exec_pkg::exec_op_t o);
        logic signed [63:0] a, b, r;
        logic               fits, exc;
        logic [31:0]        code;
        exec_pkg::wb_t      w;
        a    = {{32{o.opa[31]}}, o.opa};
        b    = {{32{o.opb[31]}}, o.opb};
        exc  = 1'b0;
        code = 32'd0;
        case (o.op)
            exec_pkg::OP_ADD: r = a + b;
            exec_pkg::OP_SUB: r = a - b;
            exec_pkg::OP_AND: r = a & b;
            exec_pkg::OP_OR:  r = a | b;
            exec_pkg::OP_SLL: r = a << o.opb[4:0];       // Low 32 bits kept below
            exec_pkg::OP_SRA: r = a >>> o.opb[4:0];
            exec_pkg::OP_MUL: r = a * b;
            exec_pkg::OP_DIV: r = (b == 64'sd0) ? 64'sd0 : a / b;  // Truncates to zero
            default:          r = 64'sd0;
        endcase
        fits = (r == {{32{r[31]}}, r[31:0]});   // Has a 32-bit signed form
        case (o.op)
            exec_pkg::OP_ADD: begin
                exc  = ~fits;
                code = exec_pkg::EXC_ADD;
            end
            exec_pkg::OP_SUB: begin
                exc  = ~fits;
                code = exec_pkg::EXC_SUB;
            end
            exec_pkg::OP_MUL: begin
                exc  = ~fits;
                code = exec_pkg::EXC_MUL;
            end
            exec_pkg::OP_DIV: begin
                exc  = (b == 64'sd0);
                code = exec_pkg::EXC_DIV;
            end
            default: exc = 1'b0;
        endcase
        w.dest  = exc ? exec_pkg::RSTATUS_REG : o.dest;  // Status write to r30
        w.value = exc ? code : r[31:0];
        return w;
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Hold op until the DUT takes it; called 1 ns after a rising edge
    task automatic send_op(input exec_pkg::exec_op_t o);
        logic taken;
        taken    = 1'b0;
        op       = o;
        op_valid = 1'b1;
        while (!taken) begin
            @(negedge clock);
            taken = op_ready;                   // Stable mid-cycle
            @(posedge clock);
            #1;
        end
        op_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Clock, wb_ready gaps, reference queue, timeout
    // ------------------------------------------------------------------
    initial begin
        clock     = 1'b0;
        cycle_cnt = 0;
        forever #5 clock = ~clock;
    end

    initial begin
        wb_ready = 1'b0;
        gap_rng  = ~SEED;
        forever begin
            @(posedge clock);
            #1;
            gap_rng  = xorshift(gap_rng);
            wb_ready = (gap_rng[1:0] != 2'b00);     // Low about a quarter of cycles
        end
    end

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (op_valid && op_ready) begin
                exp_mem[wr_ptr] <= expected_wb(op);
                wr_ptr          <= wr_ptr + 9'd1;
            end
            if (wb_valid && wb_ready) begin
                rd_ptr <= rd_ptr + 9'd1;            // Pop
            end
            held_wb <= wb;
        end
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            report_fail($sformatf("Timeout: writebacks not done after %0d cycles", MAX_CYCLES));
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_reset_state: assert property (@(posedge clock) $rose(rst_n) |-> !wb_valid && op_ready)
        else report_fail($sformatf("FAIL after reset wb_valid=%h op_ready=%h",
                                   $sampled(wb_valid), $sampled(op_ready)));

    a_wb_expected: assert property (@(posedge clock) disable iff (!rst_n)
        wb_valid && wb_ready |-> wb == exp_head)
        else report_fail($sformatf("FAIL wb=%h expected=%h (dest, value)",
                                   $sampled(wb), $sampled(exp_head)));

    // Nothing written back that was not issued
    a_wb_outstanding: assert property (@(posedge clock) disable iff (!rst_n)
        wb_valid |-> rd_ptr != wr_ptr)
        else report_fail($sformatf("FAIL wb_valid=%h with no op outstanding, wb=%h",
                                   $sampled(wb_valid), $sampled(wb)));

    a_wb_held: assert property (@(posedge clock) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb))
        else report_fail($sformatf("FAIL wb=%h wb_valid=%h while held, was wb=%h",
                                   $sampled(wb), $sampled(wb_valid), $sampled(held_wb)));

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        exec_pkg::exec_op_t o;
        logic [31:0]        r;
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        op_rng   = SEED;
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // Directed corners mixing both paths back to back
        send_op(make_op(exec_pkg::OP_ADD, 5'd1, 32'h7fff_ffff, 32'h1));    // Add overflow
        send_op(make_op(exec_pkg::OP_SUB, 5'd2, 32'h8000_0000, 32'h1));    // Sub overflow
        send_op(make_op(exec_pkg::OP_MUL, 5'd3, 32'h0001_0000, 32'h0001_0000));
        send_op(make_op(exec_pkg::OP_DIV, 5'd4, 32'd100, 32'd0));          // Zero divisor
        send_op(make_op(exec_pkg::OP_MUL, 5'd5, 32'hffff_fffd, 32'd5));    // -3 * 5
        send_op(make_op(exec_pkg::OP_DIV, 5'd6, 32'hffff_fff9, 32'd2));    // -7 / 2
        send_op(make_op(exec_pkg::OP_SRA, 5'd7, 32'h8000_0000, 32'h24));   // Shamt 4
        send_op(make_op(exec_pkg::OP_SLL, 5'd8, 32'h1, 32'hffff_ffff));    // Shamt 31

        for (int i = 8; i < N_OPS; i++) begin
            op_rng = xorshift(op_rng);
            r      = op_rng;
            o.op   = exec_pkg::op_e'({1'b0, r[2:0]});
            o.dest = r[7:3];
            op_rng = xorshift(op_rng);
            o.opa  = pick_operand(op_rng);
            op_rng = xorshift(op_rng);
            o.opb  = pick_operand(op_rng);
            if (r[10:8] == 3'd0) begin
                @(posedge clock);               // Idle cycle between ops
                #1;
            end
            send_op(o);
        end

        // Wait for the queue to drain
        while (rd_ptr != wr_ptr) begin
            @(negedge clock);
        end
        if (rd_ptr != 9'(N_OPS) || wb_valid) begin
            report_fail($sformatf("Run ended with %0d of %0d writebacks, wb_valid still %0b",
                                  rd_ptr, N_OPS, wb_valid));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
logic/exec_pkg.sv
logic/pipe_reg.sv
logic/issue_ctrl.sv
logic/alu_pipe.sv
logic/multdiv_unit.sv
logic/result_merge.sv
logic/exec_core.sv
testbench/tb_exec_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_exec_core -f tb.f || exit 1
out=$(./obj_dir/Vtb_exec_core 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
